// File: Bender.yml
package:
  name: div_unit

sources:
  - design/div_pkg.sv
  - design/div_bitcount_shift.sv
  - design/div_serial.sv
  - design/div_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_div_unit.sv

// File: compile.f
+incdir+tests
design/div_pkg.sv
design/div_bitcount_shift.sv
design/div_serial.sv
design/div_unit.sv
tests/tb_div_unit.sv

// File: design/div_bitcount_shift.sv
`timescale 1ns/10ps

module div_bitcount_shift (
  // Leading-bit count
  input  logic                          clz_en_i,
  input  logic [div_pkg::DIV_WIDTH-1:0] clz_data_i,
  output logic [5:0]                    clz_result_o,

  // Divisor alignment
  input  logic                          shift_en_i,
  input  logic [5:0]                    shift_amt_i,
  input  logic [div_pkg::DIV_WIDTH-1:0] op_b_i,
  output logic [div_pkg::DIV_WIDTH-1:0] op_b_shifted_o
);

  import div_pkg::*;

  // Stages of the barrel shifter for shifts below one full word
  localparam int unsigned SHIFT_STAGES = $clog2(DIV_WIDTH);

  logic [DIV_WIDTH-1:0] clz_data_gated;
  logic [DIV_WIDTH-1:0] op_b_gated;
  logic [5:0]           shift_amt_gated;
  logic [DIV_WIDTH-1:0] shift_stage [SHIFT_STAGES+1];

  ////////////////////////////////////////////////////////////////////////////
  // Operand gating
  ////////////////////////////////////////////////////////////////////////////

  // Disabled inputs are forced to zero so the logic stays quiet when idle
  assign clz_data_gated  = clz_en_i   ? clz_data_i  : '0;
  assign op_b_gated      = shift_en_i ? op_b_i      : '0;
  assign shift_amt_gated = shift_en_i ? shift_amt_i : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Leading-zero counter
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the LSB upwards, a later hit overrides an earlier one
  // so the highest set bit wins
  always_comb begin
    // All-zero word counts as a full word
    clz_result_o = 6'(DIV_WIDTH);
    for (int i = 0; i < DIV_WIDTH; i++) begin
      if (clz_data_gated[i]) begin
        clz_result_o = 6'(DIV_WIDTH - 1 - i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Logarithmic left shifter
  ////////////////////////////////////////////////////////////////////////////

  assign shift_stage[0] = op_b_gated;

  // Each stage shifts by a power of two, selected by one amount bit
  for (genvar k = 0; k < SHIFT_STAGES; k++) begin : g_shift_stage
    assign shift_stage[k+1] = shift_amt_gated[k] ? (shift_stage[k] << (1 << k))
                                                 : shift_stage[k];
  end

  // Top amount bit means a full-word shift, nothing is left
  assign op_b_shifted_o = shift_amt_gated[SHIFT_STAGES] ? '0
                                                        : shift_stage[SHIFT_STAGES];

endmodule : div_bitcount_shift

// File: design/div_pkg.sv
package div_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Common definitions of the integer divide unit
  ////////////////////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int unsigned DIV_WIDTH = 32;

  // Divide operators as decoded by the execute stage
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  // Serial divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'b00,
    DIV_DIVIDE = 2'b01,
    DIV_DUMMY  = 2'b10,
    DIV_FINISH = 2'b11
  } div_state_e;

  // Request towards the divider, held stable for the whole operation
  typedef struct packed {
    div_op_e              operator;
    logic [DIV_WIDTH-1:0] op_a;
    logic [DIV_WIDTH-1:0] op_b;
    // Pad every division to the same length
    logic                 data_ind_timing;
  } div_req_t;

endpackage : div_pkg

// File: design/div_serial.sv
`timescale 1ns/10ps

module div_serial (
  input  logic                          clk,
  input  logic                          rst_n,

  // Request side
  input  div_pkg::div_req_t             req_i,
  input  logic                          valid_i,
  output logic                          ready_o,

  // Leading-bit count in the shared block
  output logic                          alu_clz_en_o,
  output logic [div_pkg::DIV_WIDTH-1:0] alu_clz_data_o,
  input  logic [5:0]                    alu_clz_result_i,

  // Divisor alignment in the shared block
  output logic                          alu_shift_en_o,
  output logic [5:0]                    alu_shift_amt_o,
  input  logic [div_pkg::DIV_WIDTH-1:0] alu_op_b_shifted_i,

  // Result side
  input  logic                          ready_i,
  output logic                          valid_o,
  output logic [div_pkg::DIV_WIDTH-1:0] result_o
);

  import div_pkg::*;

  // Request fields
  div_op_e              div_op;
  logic [DIV_WIDTH-1:0] op_a;
  logic [DIV_WIDTH-1:0] op_b;
  logic                 data_ind_timing;

  // Operator decode
  logic                 div_signed;
  logic                 div_rem;
  logic                 op_a_is_neg;
  logic                 op_b_is_neg;
  logic                 op_b_is_zero;
  logic                 signs_differ;

  // Datapath
  logic [DIV_WIDTH-1:0] remainder_q;
  logic [DIV_WIDTH-1:0] divisor_q;
  logic [DIV_WIDTH-1:0] quotient_q;
  logic [DIV_WIDTH-1:0] divisor_next;
  logic [DIV_WIDTH-1:0] add_a;
  logic [DIV_WIDTH-1:0] add_b;
  logic [DIV_WIDTH-1:0] add_out;
  logic [DIV_WIDTH-1:0] res_sel;
  logic                 rem_add;
  logic                 comp_out;

  // Per-operation flags
  logic                 div_rem_q;
  logic                 comp_inv_q;
  logic                 res_inv_q;
  logic                 res_inv_init;

  // Counter
  logic [5:0]           cnt_q;
  logic [5:0]           cnt_d;
  logic [5:0]           cnt_dummy;
  logic                 cnt_is_zero;

  // FSM
  div_state_e           state_q;
  div_state_e           state_d;
  logic                 init_en;
  logic                 init_dummy_cnt;
  logic                 remainder_en;
  logic                 divisor_en;
  logic                 quotient_en;

  ////////////////////////////////////////////////////////////////////////////
  // Operator decoding
  ////////////////////////////////////////////////////////////////////////////

  assign div_op          = req_i.operator;
  assign op_a            = req_i.op_a;
  assign op_b            = req_i.op_b;
  assign data_ind_timing = req_i.data_ind_timing;

  assign div_signed = (div_op == DIV_DIV) || (div_op == DIV_REM);
  assign div_rem    = (div_op == DIV_REM) || (div_op == DIV_REMU);

  // Sign bits only count for the signed operators
  assign op_a_is_neg  = op_a[DIV_WIDTH-1] & div_signed;
  assign op_b_is_neg  = op_b[DIV_WIDTH-1] & div_signed;
  assign op_b_is_zero = ~(|op_b);
  assign signs_differ = op_a_is_neg ^ op_b_is_neg;

  ////////////////////////////////////////////////////////////////////////////
  // Count and shift requests
  ////////////////////////////////////////////////////////////////////////////

  // Both blocks are only active while a request is pending
  assign alu_clz_en_o   = valid_i;
  assign alu_shift_en_o = valid_i;

  // Negative divisor is inverted so its leading ones get counted
  assign alu_clz_data_o = op_b_is_neg ? ~op_b : op_b;

  // Align the divisor MSB with the dividend MSB
  // one place less for a negative divisor to keep its sign bit
  assign alu_shift_amt_o = alu_clz_result_i - (op_b_is_neg ? 6'd1 : 6'd0);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Remainder starts as the dividend, negated when the signs differ
  assign rem_add = init_en && !signs_differ;

  // Shared adder
  // init  0 + op_a or 0 - op_a
  // loop  remainder - divisor
  assign add_a   = init_en ? op_a : divisor_q;
  assign add_b   = init_en ? '0   : remainder_q;
  assign add_out = rem_add ? (add_b + add_a) : (add_b - add_a);

  // Aligned divisor on init, then one place right with sign fill
  assign divisor_next = init_en ? alu_op_b_shifted_i
                                : {comp_inv_q, divisor_q[DIV_WIDTH-1:1]};

  // Subtract when the remainder magnitude reaches the divisor
  // the comparison flips for a negative divisor
  // a zero remainder only subtracts for a zero divisor
  assign comp_out = ((remainder_q == divisor_q) ||
                     ((remainder_q > divisor_q) ^ comp_inv_q)) &&
                    ((|remainder_q) || op_b_is_zero);

  // Result select and final negation
  assign res_sel  = div_rem_q ? remainder_q : quotient_q;
  assign result_o = res_inv_q ? (~res_sel + 1'b1) : res_sel;

  // Negate for differing signs, except the quotient of a zero divisor
  assign res_inv_init = (!op_b_is_zero || div_rem) && signs_differ;

  ////////////////////////////////////////////////////////////////////////////
  // Counter
  ////////////////////////////////////////////////////////////////////////////

  // Padding length so every run covers a full word
  assign cnt_dummy   = 6'(DIV_WIDTH) - alu_shift_amt_o;
  assign cnt_is_zero = ~(|cnt_q);

  always_comb begin
    cnt_d = cnt_q;
    if (init_en) begin
      cnt_d = alu_shift_amt_o;
    end else if (init_dummy_cnt) begin
      // One padding cycle is spent loading the counter
      cnt_d = cnt_dummy - 6'd1;
    end else if (!cnt_is_zero) begin
      cnt_d = cnt_q - 6'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    valid_o        = 1'b0;
    ready_o        = 1'b0;
    init_en        = 1'b0;
    init_dummy_cnt = 1'b0;
    remainder_en   = 1'b0;
    divisor_en     = 1'b0;
    quotient_en    = 1'b0;

    case (state_q)
      // Load operands on the first cycle with a request
      DIV_IDLE: begin
        init_en      = 1'b1;
        remainder_en = 1'b1;
        divisor_en   = 1'b1;
        state_d      = DIV_DIVIDE;
      end

      // One quotient bit per cycle
      DIV_DIVIDE: begin
        remainder_en = comp_out;
        divisor_en   = 1'b1;
        quotient_en  = 1'b1;
        if (cnt_is_zero) begin
          if (data_ind_timing && (|cnt_dummy)) begin
            init_dummy_cnt = 1'b1;
            state_d        = DIV_DUMMY;
          end else begin
            state_d = DIV_FINISH;
          end
        end
      end

      // Padding only, datapath holds
      DIV_DUMMY: begin
        if (cnt_is_zero) begin
          state_d = DIV_FINISH;
        end
      end

      // Hold the result until it is taken
      DIV_FINISH: begin
        valid_o = 1'b1;
        if (ready_i) begin
          ready_o = 1'b1;
          state_d = DIV_IDLE;
        end
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase

    // Dropped request kills the operation in any state
    if (!valid_i) begin
      state_d        = DIV_IDLE;
      valid_o        = 1'b0;
      ready_o        = 1'b1;
      init_en        = 1'b0;
      init_dummy_cnt = 1'b0;
      remainder_en   = 1'b0;
      divisor_en     = 1'b0;
      quotient_en    = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= DIV_IDLE;
      cnt_q      <= '0;
      div_rem_q  <= 1'b0;
      comp_inv_q <= 1'b0;
      res_inv_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      // Flags are captured together with the operands
      if (init_en) begin
        div_rem_q  <= div_rem;
        comp_inv_q <= op_b_is_neg;
        res_inv_q  <= res_inv_init;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (remainder_en) begin
      remainder_q <= add_out;
    end
    if (divisor_en) begin
      divisor_q <= divisor_next;
    end
    if (init_en) begin
      quotient_q <= '0;
    end else if (quotient_en) begin
      quotient_q <= {quotient_q[DIV_WIDTH-2:0], comp_out};
    end
  end

endmodule : div_serial

// File: design/div_unit.sv
`timescale 1ns/10ps

module div_unit (
  input  logic                          clk,
  input  logic                          rst_n,

  // Request side
  input  div_pkg::div_req_t             req_i,
  input  logic                          valid_i,
  output logic                          ready_o,

  // Result side
  input  logic                          ready_i,
  output logic                          valid_o,
  output logic [div_pkg::DIV_WIDTH-1:0] result_o
);

  import div_pkg::*;

  // Links between the divider and the shared count and shift block
  logic                 clz_en;
  logic [DIV_WIDTH-1:0] clz_data;
  logic [5:0]           clz_result;
  logic                 shift_en;
  logic [5:0]           shift_amt;
  logic [DIV_WIDTH-1:0] op_b_shifted;

  ////////////////////////////////////////////////////////////////////////////
  // Serial divider
  ////////////////////////////////////////////////////////////////////////////

  div_serial u_div_serial (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_i              (req_i),
    .valid_i            (valid_i),
    .ready_o            (ready_o),
    .alu_clz_en_o       (clz_en),
    .alu_clz_data_o     (clz_data),
    .alu_clz_result_i   (clz_result),
    .alu_shift_en_o     (shift_en),
    .alu_shift_amt_o    (shift_amt),
    .alu_op_b_shifted_i (op_b_shifted),
    .ready_i            (ready_i),
    .valid_o            (valid_o),
    .result_o           (result_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Count and shift, the divisor comes straight from the request
  ////////////////////////////////////////////////////////////////////////////

  div_bitcount_shift u_div_bitcount_shift (
    .clz_en_i       (clz_en),
    .clz_data_i     (clz_data),
    .clz_result_o   (clz_result),
    .shift_en_i     (shift_en),
    .shift_amt_i    (shift_amt),
    .op_b_i         (req_i.op_b),
    .op_b_shifted_o (op_b_shifted)
  );

endmodule : div_unit

// File: tests/tb_div_model.svh
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// LFSR state and running check counts
logic [31:0] lfsr_state;
int unsigned check_count;
int unsigned error_count;

////////////////////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] next_random(input int unsigned nbits);
  logic [31:0] value;
  logic        fb;
  value = '0;
  for (int i = 0; i < nbits; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    value      = {value[30:0], fb};
  end
  return value;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference division
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] divide_model(input div_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
  logic [31:0] quot;
  logic [31:0] rem;
  if (b == '0) begin
    // Zero divisor gives all ones and the dividend back
    quot = '1;
    rem  = a;
  end else if (op == DIV_DIVU || op == DIV_REMU) begin
    quot = a / b;
    rem  = a % b;
  end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
    // Signed overflow
    quot = a;
    rem  = '0;
  end else begin
    // Truncation toward zero, remainder follows the dividend sign
    quot = $signed(a) / $signed(b);
    rem  = $signed(a) % $signed(b);
  end
  return (op == DIV_REM || op == DIV_REMU) ? rem : quot;
endfunction

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
  end
endtask

`endif

// File: tests/tb_div_unit.sv
`timescale 1ns/10ps

module tb_div_unit;

  import div_pkg::*;

  // Cycles to wait for a result
  localparam int unsigned OP_TIMEOUT  = 100;
  // Fixed run length with data-independent timing
  localparam int unsigned DIT_LATENCY = 34;

  logic                 clk = 1'b0;
  logic                 rst_n;
  div_req_t             req_i;
  logic                 valid_i;
  logic                 ready_o;
  logic                 ready_i;
  logic                 valid_o;
  logic [DIV_WIDTH-1:0] result_o;
  logic                 timed_out;

  `include "tb_div_model.svh"

  always #4 clk = ~clk;

  div_unit dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Operator bit 0 selects unsigned and bit 1 selects remainder
  function automatic div_req_t random_req(input logic is_signed, input logic dit);
    div_req_t   req;
    logic       rem_bit;
    logic [4:0] shift;
    rem_bit      = 1'(next_random(1));
    req.operator = div_op_e'({rem_bit, ~is_signed});
    req.op_a     = next_random(32);
    // Fewer significant bits in the divisor
    shift        = 5'(next_random(5));
    req.op_b     = next_random(32) >> shift;
    if (is_signed && next_random(1) != 0) begin
      req.op_b = -req.op_b;
    end
    req.data_ind_timing = dit;
    return req;
  endfunction

  // Starts at the drive point with the DUT idle and ends at a later one
  task automatic run_op(input div_req_t req, input int unsigned hold,
                        output logic [31:0] res, output int unsigned latency);
    res     = '0;
    latency = 0;
    if (timed_out) begin
      return;
    end
    req_i   = req;
    valid_i = 1'b1;
    ready_i = 1'b0;
    // Edges counted from the one that loads the operands
    while (!valid_o && latency < OP_TIMEOUT) begin
      @(posedge clk);
      #1;
      latency++;
      check_value(ready_o, 1'b0, "ready_o high before the result was taken");
    end
    if (!valid_o) begin
      $display("Timeout at %0t ns: no result from the divider within %0d cycles",
               $time, OP_TIMEOUT);
      error_count++;
      timed_out = 1'b1;
      valid_i   = 1'b0;
      return;
    end
    res = result_o;
    // Result must hold under back-pressure
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #1;
      check_value(valid_o, 1'b1, "valid_o dropped under back-pressure");
      check_value(result_o, res, "result_o changed under back-pressure");
      check_value(ready_o, 1'b0, "ready_o high before ready_i");
    end
    ready_i = 1'b1;
    #1;
    check_value(ready_o, 1'b1, "ready_o missing when the result is taken");
    @(posedge clk);
    #1;
    // Back in idle while the request is still applied
    check_value(valid_o, 1'b0, "valid_o high after the result was taken");
    check_value(ready_o, 1'b0, "ready_o high after the result was taken");
    valid_i = 1'b0;
    ready_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic run_and_check(input div_req_t req, input int unsigned hold,
                               input string what);
    logic [31:0] res;
    int unsigned latency;
    run_op(req, hold, res, latency);
    if (!timed_out) begin
      check_value(res, divide_model(req.operator, req.op_a, req.op_b),
                  $sformatf("%s %s %h %h", what, req.operator.name(), req.op_a, req.op_b));
      if (req.data_ind_timing) begin
        check_value(latency, DIT_LATENCY, $sformatf("%s latency", what));
      end
    end
  endtask

  // Literal expected value straight from the ISA rules
  task automatic corner(input div_op_e op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] expected);
    div_req_t    req;
    logic [31:0] res;
    int unsigned latency;
    req = '{operator: op, op_a: a, op_b: b, data_ind_timing: 1'b0};
    run_op(req, 0, res, latency);
    if (!timed_out) begin
      check_value(res, expected, $sformatf("corner %s %h %h", op.name(), a, b));
    end
  endtask

  task automatic kill_then_run();
    div_req_t    req;
    int unsigned kill_at;
    if (timed_out) begin
      return;
    end
    req      = random_req(1'(next_random(1)), 1'b0);
    // Divisor of one gives the longest loop
    req.op_b = 32'd1;
    kill_at  = next_random(3) + 1;
    req_i    = req;
    valid_i  = 1'b1;
    for (int i = 0; i < kill_at; i++) begin
      @(posedge clk);
      #1;
      check_value(valid_o, 1'b0, "valid_o high mid division");
    end
    valid_i = 1'b0;
    #1;
    check_value(ready_o, 1'b1, "ready_o low after kill");
    check_value(valid_o, 1'b0, "valid_o high after kill");
    @(posedge clk);
    #1;
    run_and_check(random_req(1'(next_random(1)), 1'b0), 0, "after kill");
  endtask

  task automatic report_test(input string name, input int unsigned c0, input int unsigned e0);
    $display("%s: %0d checks, %0d errors", name, check_count - c0, error_count - e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned c0;
    int unsigned e0;
    div_req_t    req;
    lfsr_state  = 32'hede;
    check_count = 0;
    error_count = 0;
    timed_out   = 1'b0;
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    ready_i     = 1'b0;
    req_i       = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    c0 = check_count;
    e0 = error_count;
    check_value(valid_o, 1'b0, "valid_o after reset");
    check_value(ready_o, 1'b1, "ready_o idle after reset");
    report_test("reset", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < 200; i++) begin
      run_and_check(random_req(1'b0, 1'b0), 0, "unsigned");
    end
    report_test("unsigned division", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < 200; i++) begin
      run_and_check(random_req(1'b1, 1'b0), 0, "signed");
    end
    report_test("signed division", c0, e0);

    c0 = check_count;
    e0 = error_count;
    corner(DIV_DIV,  32'h1234_5678, 32'h0, 32'hffff_ffff);
    corner(DIV_DIV,  32'h8765_4321, 32'h0, 32'hffff_ffff);
    corner(DIV_DIVU, 32'h1234_5678, 32'h0, 32'hffff_ffff);
    corner(DIV_REM,  32'h8765_4321, 32'h0, 32'h8765_4321);
    corner(DIV_REMU, 32'h8765_4321, 32'h0, 32'h8765_4321);
    corner(DIV_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    corner(DIV_REM,  32'h8000_0000, 32'hffff_ffff, 32'h0);
    corner(DIV_DIVU, 32'd7, 32'd9, 32'd0);
    corner(DIV_REMU, 32'd7, 32'd9, 32'd7);
    corner(DIV_DIV,  32'hffff_fff9, 32'd9, 32'd0);
    corner(DIV_REM,  32'hffff_fff9, 32'd9, 32'hffff_fff9);
    corner(DIV_REM,  32'd7, 32'hffff_fff7, 32'd7);
    report_test("corner cases", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < 40; i++) begin
      req = random_req(1'(next_random(1)), 1'b1);
      // Zero divisor now and then
      if (i % 8 == 0) begin
        req.op_b = '0;
      end
      run_and_check(req, 0, "fixed timing");
    end
    report_test("data-independent timing", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < 30; i++) begin
      req = random_req(1'(next_random(1)), 1'(next_random(1)));
      run_and_check(req, next_random(4) + 1, "back-pressure");
    end
    report_test("back-pressure", c0, e0);

    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < 10; i++) begin
      kill_then_run();
    end
    report_test("kill", c0, e0);

    $display("Total: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_div_unit
